/* hw/nice_pkg.sv */
// nice coprocessor shared types, opcodes and conv1 quantization constants
package nice_pkg;

  typedef logic [31:0] xlen_t;

  typedef logic        [7:0]  uint8_t;
  typedef logic signed [7:0]  int8_t;
  typedef logic signed [8:0]  int9_t;
  typedef logic signed [31:0] acc_t;

  typedef enum logic [2:0] {
    op_none,
    op_load_conv1,
    op_load_input,
    op_store_conv1,
    op_illegal
  } nice_op_e;

  typedef enum logic [2:0] {
    st_idle,
    st_load_conv1,
    st_load_input,
    st_cal_conv1,
    st_store_conv1,
    st_respond
  } ctrl_state_e;

  // icb command and response beats
  typedef struct packed {
    logic       valid;
    xlen_t      addr;
    logic       read;
    xlen_t      wdata;
    logic [1:0] size;
  } icb_cmd_t;

  typedef struct packed {
    logic  valid;
    xlen_t rdata;
    logic  err;
  } icb_rsp_t;

  // one multi-word transfer handed to the memory agent
  typedef struct packed {
    logic       start;
    xlen_t      base;
    logic       read;
    logic [7:0] words;
  } mem_job_t;

  // custom3 R-type encoding
  localparam logic [6:0] custom3_opcode    = 7'h7b;
  localparam logic [2:0] load_func3        = 3'b010;
  localparam logic [6:0] func7_load_conv1  = 7'h0b;
  localparam logic [6:0] func7_load_input  = 7'h0f;
  localparam logic [6:0] func7_store_conv1 = 7'h10;

  // conv1 quantization
  localparam uint8_t input_zp        = 8'd127;
  localparam uint8_t conv1_weight_zp = 8'd2;
  localparam uint8_t conv1_out_zp    = 8'd159;
  localparam acc_t   conv1_bias [5]  = '{871, -16316, -9617, -21527, -7265};

endpackage

/* hw/nice_ctrl.sv */
// nice controller decoding custom3 requests, sequencing jobs and answering the host
`timescale 1ns/1ns

module nice_ctrl #(
  parameter int img_width  = 8,
  parameter int kern_num   = 5,
  parameter int kern_width = 3
) (
  input  logic               nice_clk,
  input  logic               nice_rst_n,
  input  logic               req_valid,
  input  nice_pkg::xlen_t    req_inst,
  input  nice_pkg::xlen_t    req_rs1,
  output logic               req_ready,
  output logic               rsp_valid,
  output nice_pkg::xlen_t    rsp_rdat,
  output logic               rsp_err,
  input  logic               rsp_ready,
  output nice_pkg::mem_job_t mem_job,
  output nice_pkg::nice_op_e buf_sel,
  input  logic               job_done,
  input  logic               job_err,
  output logic               cal_start,
  input  logic               cal_done,
  output logic               nice_active,
  output logic               nice_mem_holdup
);
  import nice_pkg::*;

  localparam int out_w = img_width / 2 - kern_width + 1;
  localparam logic [7:0] kern_words = 8'((kern_num * kern_width * kern_width + 3) / 4);
  localparam logic [7:0] img_words  = 8'((img_width * img_width + 3) / 4);
  localparam logic [7:0] res_words  = 8'((kern_num * out_w * out_w + 3) / 4);

  ctrl_state_e state;
  nice_op_e    dec_op;
  nice_op_e    op_q;
  logic        illegal_q;
  logic        req_hs;

  assign req_hs = req_valid & req_ready;

  // R-type decode, anything unknown is illegal
  always_comb begin
    dec_op = op_illegal;
    if ((req_inst[6:0] == custom3_opcode) && (req_inst[14:12] == load_func3)) begin
      case (req_inst[31:25])
        func7_load_conv1:  dec_op = op_load_conv1;
        func7_load_input:  dec_op = op_load_input;
        func7_store_conv1: dec_op = op_store_conv1;
        default:           dec_op = op_illegal;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      state     <= st_idle;
      op_q      <= op_none;
      illegal_q <= 1'b0;
      mem_job   <= '0;
      cal_start <= 1'b0;
    end else begin
      mem_job.start <= 1'b0;
      cal_start     <= 1'b0;
      case (state)
        st_idle: begin
          if (req_hs) begin
            op_q      <= dec_op;
            illegal_q <= (dec_op == op_illegal);
            case (dec_op)
              op_load_conv1: begin
                state   <= st_load_conv1;
                mem_job <= '{start: 1'b1, base: req_rs1, read: 1'b1, words: kern_words};
              end
              op_load_input: begin
                state   <= st_load_input;
                mem_job <= '{start: 1'b1, base: req_rs1, read: 1'b1, words: img_words};
              end
              op_store_conv1: begin
                state   <= st_store_conv1;
                mem_job <= '{start: 1'b1, base: req_rs1, read: 1'b0, words: res_words};
              end
              default: state <= st_respond;
            endcase
          end
        end
        st_load_conv1, st_store_conv1: begin
          if (job_done) begin
            state <= st_respond;
          end
        end
        // image load chains straight into the conv1 pass
        st_load_input: begin
          if (job_done) begin
            state     <= st_cal_conv1;
            cal_start <= 1'b1;
          end
        end
        st_cal_conv1: begin
          if (cal_done) begin
            state <= st_respond;
          end
        end
        st_respond: begin
          if (rsp_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign req_ready       = (state == st_idle);
  assign rsp_valid       = (state == st_respond);
  assign rsp_err         = illegal_q | job_err;
  assign rsp_rdat        = '0;
  assign buf_sel         = op_q;
  assign nice_active     = (state != st_idle);
  assign nice_mem_holdup = (state == st_load_conv1) | (state == st_load_input) |
                           (state == st_store_conv1);

endmodule

/* hw/nice_mem_agent.sv */
// memory agent issuing word commands on the icb bus and tracking returning responses
`timescale 1ns/1ns

module nice_mem_agent (
  input  logic               nice_clk,
  input  logic               nice_rst_n,
  input  nice_pkg::mem_job_t mem_job,
  output logic               job_done,
  output logic               job_err,
  output nice_pkg::icb_cmd_t icb_cmd,
  input  logic               icb_cmd_ready,
  input  nice_pkg::icb_rsp_t icb_rsp,
  output logic               icb_rsp_ready,
  output logic               rd_valid,
  output nice_pkg::xlen_t    rd_word,
  output logic [7:0]         word_idx,
  input  nice_pkg::xlen_t    wr_word
);
  import nice_pkg::*;

  logic       busy_q;
  logic       read_q;
  logic       err_q;
  xlen_t      addr_q;
  logic [7:0] words_q;
  logic [7:0] issued_q;
  logic [7:0] recvd_q;
  // at most four commands in flight
  logic [2:0] outst_q;
  logic       cmd_valid;
  logic       cmd_hs;
  logic       rsp_hs;

  assign cmd_valid = busy_q && (issued_q < words_q) && (outst_q < 3'd4);
  assign cmd_hs    = cmd_valid & icb_cmd_ready;
  assign rsp_hs    = busy_q & icb_rsp.valid;

  always_comb begin
    icb_cmd.valid = cmd_valid;
    icb_cmd.addr  = addr_q;
    icb_cmd.read  = read_q;
    icb_cmd.wdata = read_q ? '0 : wr_word;
    icb_cmd.size  = 2'b10;
  end

  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      busy_q   <= 1'b0;
      read_q   <= 1'b1;
      err_q    <= 1'b0;
      addr_q   <= '0;
      words_q  <= '0;
      issued_q <= '0;
      recvd_q  <= '0;
      outst_q  <= '0;
    end else if (mem_job.start) begin
      busy_q   <= 1'b1;
      read_q   <= mem_job.read;
      err_q    <= 1'b0;
      addr_q   <= mem_job.base;
      words_q  <= mem_job.words;
      issued_q <= '0;
      recvd_q  <= '0;
      outst_q  <= '0;
    end else if (busy_q) begin
      if (cmd_hs) begin
        addr_q   <= addr_q + 32'd4;
        issued_q <= issued_q + 8'd1;
      end
      if (rsp_hs) begin
        recvd_q <= recvd_q + 8'd1;
        err_q   <= err_q | icb_rsp.err;
      end
      case ({cmd_hs, rsp_hs})
        2'b10:   outst_q <= outst_q + 3'd1;
        2'b01:   outst_q <= outst_q - 3'd1;
        default: outst_q <= outst_q;
      endcase
      if (job_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign job_done      = rsp_hs && (recvd_q == words_q - 8'd1);
  assign job_err       = err_q;
  assign icb_rsp_ready = 1'b1;

  // reads index by response, writes fetch data for the command being issued
  assign rd_valid = rsp_hs & read_q;
  assign rd_word  = icb_rsp.rdata;
  assign word_idx = read_q ? recvd_q : issued_q;

endmodule

/* hw/conv1_buffers.sv */
// conv1 kernel and image stores with tap lookup and 2x2 max pooling on read
`timescale 1ns/1ns

module conv1_buffers #(
  parameter int img_width  = 8,
  parameter int kern_num   = 5,
  parameter int kern_width = 3
) (
  input  logic                                  nice_clk,
  input  logic                                  nice_rst_n,
  input  nice_pkg::nice_op_e                    buf_sel,
  input  logic                                  rd_valid,
  input  nice_pkg::xlen_t                       rd_word,
  input  logic [7:0]                            word_idx,
  input  logic [$clog2(kern_num)-1:0]           tap_kern,
  input  logic [$clog2(kern_width*kern_width)-1:0] tap_idx,
  input  logic [$clog2(img_width/2)-1:0]        pix_row,
  input  logic [$clog2(img_width/2)-1:0]        pix_col,
  output nice_pkg::int8_t                       tap_weight,
  output nice_pkg::uint8_t                      pool_px
);
  import nice_pkg::*;

  localparam int taps      = kern_width * kern_width;
  localparam int kern_size = kern_num * taps;
  localparam int img_size  = img_width * img_width;

  int8_t  kern_mem [kern_size];
  uint8_t img_mem  [img_size];

  // unpack one loaded word, byte 0 from the low bits
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      kern_mem <= '{default: '0};
      img_mem  <= '{default: '0};
    end else if (rd_valid) begin
      for (int b = 0; b < 4; b++) begin
        if ((buf_sel == op_load_conv1) && (int'(word_idx) * 4 + b < kern_size)) begin
          kern_mem[int'(word_idx) * 4 + b] <= int8_t'(rd_word[8*b +: 8]);
        end
        if ((buf_sel == op_load_input) && (int'(word_idx) * 4 + b < img_size)) begin
          img_mem[int'(word_idx) * 4 + b] <= rd_word[8*b +: 8];
        end
      end
    end
  end

  assign tap_weight = kern_mem[int'(tap_kern) * taps + int'(tap_idx)];

  // max of the 2x2 block under the pooled pixel
  always_comb begin
    int     base;
    uint8_t m0;
    uint8_t m1;
    base    = 2 * int'(pix_row) * img_width + 2 * int'(pix_col);
    m0      = (img_mem[base] > img_mem[base+1]) ? img_mem[base] : img_mem[base+1];
    m1      = (img_mem[base+img_width] > img_mem[base+img_width+1]) ?
              img_mem[base+img_width] : img_mem[base+img_width+1];
    pool_px = (m0 > m1) ? m0 : m1;
  end

endmodule

/* hw/conv1_engine.sv */
// conv1 engine running one MAC per cycle, then bias, requantization and clamp
`timescale 1ns/1ns

module conv1_engine #(
  parameter int img_width  = 8,
  parameter int kern_num   = 5,
  parameter int kern_width = 3
) (
  input  logic                                     nice_clk,
  input  logic                                     nice_rst_n,
  input  logic                                     cal_start,
  output logic                                     cal_done,
  output logic [$clog2(kern_num)-1:0]              tap_kern,
  output logic [$clog2(kern_width*kern_width)-1:0] tap_idx,
  output logic [$clog2(img_width/2)-1:0]           pix_row,
  output logic [$clog2(img_width/2)-1:0]           pix_col,
  input  nice_pkg::int8_t                          tap_weight,
  input  nice_pkg::uint8_t                         pool_px,
  input  logic [7:0]                               word_idx,
  output nice_pkg::xlen_t                          wr_word
);
  import nice_pkg::*;

  localparam int out_w    = img_width / 2 - kern_width + 1;
  localparam int res_size = kern_num * out_w * out_w;
  localparam int kb       = $clog2(kern_num);
  localparam int tb       = $clog2(kern_width * kern_width);
  localparam int pb       = $clog2(img_width / 2);
  localparam int rb       = $clog2(res_size);

  logic          busy_q;
  logic          done_q;
  logic [kb-1:0] kern_q;
  logic [pb-1:0] orow_q;
  logic [pb-1:0] ocol_q;
  logic [pb-1:0] tr_q;
  logic [pb-1:0] tc_q;
  logic [rb-1:0] res_ptr;
  acc_t          acc_q;
  uint8_t        res_mem [res_size];

  int9_t  w_term;
  int9_t  x_term;
  acc_t   total;
  acc_t   scaled;
  acc_t   q_val;
  uint8_t q_byte;
  logic   last_tap;

  assign tap_kern = kern_q;
  assign tap_idx  = tb'(int'(tr_q) * kern_width + int'(tc_q));
  assign pix_row  = orow_q + tr_q;
  assign pix_col  = ocol_q + tc_q;
  assign last_tap = (tr_q == pb'(kern_width - 1)) && (tc_q == pb'(kern_width - 1));

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    w_term = int9_t'(tap_weight) - int9_t'({1'b0, conv1_weight_zp});
    x_term = int9_t'({1'b0, pool_px}) - int9_t'({1'b0, input_zp});
    total  = acc_q + acc_t'(w_term) * acc_t'(x_term);
    // scale 1/510 taken as (1 + 1/256) / 512
    scaled = total + conv1_bias[kern_q];
    scaled = scaled + (scaled >>> 8);
    q_val  = (scaled >>> 9) + acc_t'(conv1_out_zp);
    if (q_val < acc_t'(conv1_out_zp)) begin
      q_byte = conv1_out_zp;
    end else if (q_val > 32'sd255) begin
      q_byte = 8'd255;
    end else begin
      q_byte = q_val[7:0];
    end
  end

  // loop order is kernel, output row, output column, then tap
  always_ff @(posedge nice_clk or negedge nice_rst_n) begin
    if (!nice_rst_n) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      kern_q  <= '0;
      orow_q  <= '0;
      ocol_q  <= '0;
      tr_q    <= '0;
      tc_q    <= '0;
      res_ptr <= '0;
      acc_q   <= '0;
    end else begin
      done_q <= 1'b0;
      if (cal_start) begin
        busy_q  <= 1'b1;
        kern_q  <= '0;
        orow_q  <= '0;
        ocol_q  <= '0;
        tr_q    <= '0;
        tc_q    <= '0;
        res_ptr <= '0;
        acc_q   <= '0;
      end else if (busy_q) begin
        if (last_tap) begin
          acc_q   <= '0;
          tr_q    <= '0;
          tc_q    <= '0;
          res_ptr <= res_ptr + 1'b1;
          if (ocol_q != pb'(out_w - 1)) begin
            ocol_q <= ocol_q + 1'b1;
          end else begin
            ocol_q <= '0;
            if (orow_q != pb'(out_w - 1)) begin
              orow_q <= orow_q + 1'b1;
            end else begin
              orow_q <= '0;
              if (kern_q != kb'(kern_num - 1)) begin
                kern_q <= kern_q + 1'b1;
              end else begin
                kern_q <= '0;
                busy_q <= 1'b0;
                done_q <= 1'b1;
              end
            end
          end
        end else begin
          acc_q <= total;
          if (tc_q == pb'(kern_width - 1)) begin
            tc_q <= '0;
            tr_q <= tr_q + 1'b1;
          end else begin
            tc_q <= tc_q + 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge nice_clk) begin
    if (busy_q && last_tap) begin
      res_mem[res_ptr] <= q_byte;
    end
  end

  assign cal_done = done_q;

  // four result bytes per store word, zero past the end
  always_comb begin
    wr_word = '0;
    for (int b = 0; b < 4; b++) begin
      if (int'(word_idx) * 4 + b < res_size) begin
        wr_word[8*b +: 8] = res_mem[int'(word_idx) * 4 + b];
      end
    end
  end

endmodule

/* hw/nice_core_top.sv */
// nice core top level joining the controller, memory agent, conv1 buffers and engine
`timescale 1ns/1ns

module nice_core_top #(
  parameter int img_width  = 8,
  parameter int kern_num   = 5,
  parameter int kern_width = 3
) (
  input  logic              nice_clk,
  input  logic              nice_rst_n,
  input  logic              req_valid,
  input  nice_pkg::xlen_t   req_inst,
  input  nice_pkg::xlen_t   req_rs1,
  output logic              req_ready,
  output logic              rsp_valid,
  output nice_pkg::xlen_t   rsp_rdat,
  output logic              rsp_err,
  input  logic              rsp_ready,
  output nice_pkg::icb_cmd_t icb_cmd,
  input  logic              icb_cmd_ready,
  input  nice_pkg::icb_rsp_t icb_rsp,
  output logic              icb_rsp_ready,
  output logic              nice_active,
  output logic              nice_mem_holdup
);
  import nice_pkg::*;

  localparam int kb = $clog2(kern_num);
  localparam int tb = $clog2(kern_width * kern_width);
  localparam int pb = $clog2(img_width / 2);

  mem_job_t       mem_job;
  nice_op_e       buf_sel;
  logic           job_done;
  logic           job_err;
  logic           cal_start;
  logic           cal_done;
  logic           rd_valid;
  xlen_t          rd_word;
  logic [7:0]     word_idx;
  xlen_t          wr_word;
  logic [kb-1:0]  tap_kern;
  logic [tb-1:0]  tap_idx;
  logic [pb-1:0]  pix_row;
  logic [pb-1:0]  pix_col;
  int8_t          tap_weight;
  uint8_t         pool_px;

  nice_ctrl #(
    .img_width (img_width),
    .kern_num  (kern_num),
    .kern_width(kern_width)
  ) u_nice_ctrl (
    .nice_clk       (nice_clk),
    .nice_rst_n     (nice_rst_n),
    .req_valid      (req_valid),
    .req_inst       (req_inst),
    .req_rs1        (req_rs1),
    .req_ready      (req_ready),
    .rsp_valid      (rsp_valid),
    .rsp_rdat       (rsp_rdat),
    .rsp_err        (rsp_err),
    .rsp_ready      (rsp_ready),
    .mem_job        (mem_job),
    .buf_sel        (buf_sel),
    .job_done       (job_done),
    .job_err        (job_err),
    .cal_start      (cal_start),
    .cal_done       (cal_done),
    .nice_active    (nice_active),
    .nice_mem_holdup(nice_mem_holdup)
  );

  nice_mem_agent u_nice_mem_agent (
    .nice_clk     (nice_clk),
    .nice_rst_n   (nice_rst_n),
    .mem_job      (mem_job),
    .job_done     (job_done),
    .job_err      (job_err),
    .icb_cmd      (icb_cmd),
    .icb_cmd_ready(icb_cmd_ready),
    .icb_rsp      (icb_rsp),
    .icb_rsp_ready(icb_rsp_ready),
    .rd_valid     (rd_valid),
    .rd_word      (rd_word),
    .word_idx     (word_idx),
    .wr_word      (wr_word)
  );

  conv1_buffers #(
    .img_width (img_width),
    .kern_num  (kern_num),
    .kern_width(kern_width)
  ) u_conv1_buffers (
    .nice_clk  (nice_clk),
    .nice_rst_n(nice_rst_n),
    .buf_sel   (buf_sel),
    .rd_valid  (rd_valid),
    .rd_word   (rd_word),
    .word_idx  (word_idx),
    .tap_kern  (tap_kern),
    .tap_idx   (tap_idx),
    .pix_row   (pix_row),
    .pix_col   (pix_col),
    .tap_weight(tap_weight),
    .pool_px   (pool_px)
  );

  conv1_engine #(
    .img_width (img_width),
    .kern_num  (kern_num),
    .kern_width(kern_width)
  ) u_conv1_engine (
    .nice_clk  (nice_clk),
    .nice_rst_n(nice_rst_n),
    .cal_start (cal_start),
    .cal_done  (cal_done),
    .tap_kern  (tap_kern),
    .tap_idx   (tap_idx),
    .pix_row   (pix_row),
    .pix_col   (pix_col),
    .tap_weight(tap_weight),
    .pool_px   (pool_px),
    .word_idx  (word_idx),
    .wr_word   (wr_word)
  );

endmodule

/* verif/tb_icb_mem.sv */
// icb memory model with random ready stalls, delayed in-order responses and error injection
`timescale 1ns/1ns

module tb_icb_mem (
  input  logic               nice_clk,
  input  logic               nice_rst_n,
  input  nice_pkg::icb_cmd_t cmd,
  output logic               cmd_ready,
  output nice_pkg::icb_rsp_t rsp,
  input  logic               rsp_ready,
  input  nice_pkg::xlen_t    err_addr
);
  import nice_pkg::*;

  logic [31:0] mem [1024];
  integer      seed;
  int          cycle;
  logic        rst_seen;
  logic        hs_seen;
  icb_cmd_t    cmd_seen;
  icb_rsp_t    rsp_q [$];
  int          due_q [$];

  initial begin
    seed      = 32'hf81d7f39;
    cycle     = 0;
    hs_seen   = 1'b0;
    rst_seen  = 1'b0;
    cmd_ready = 1'b0;
    rsp       = '0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'hc0de0000 | 32'(i);
    end
    $readmemh("verif/nice_input.txt", mem);
  end

  // bus sampled mid cycle, acted on just after the next edge
  always @(negedge nice_clk) begin
    rst_seen = nice_rst_n;
    hs_seen  = cmd.valid & cmd_ready;
    cmd_seen = cmd;
  end

  always @(posedge nice_clk) begin
    icb_rsp_t beat;
    #1;
    cycle = cycle + 1;
    if (!rst_seen) begin
      cmd_ready = 1'b0;
      rsp       = '0;
    end else begin
      if (hs_seen) begin
        beat.valid = 1'b1;
        beat.err   = (cmd_seen.addr == err_addr);
        beat.rdata = cmd_seen.read ? mem[cmd_seen.addr[11:2]] : '0;
        if (!cmd_seen.read) begin
          mem[cmd_seen.addr[11:2]] = cmd_seen.wdata;
        end
        rsp_q.push_back(beat);
        due_q.push_back(cycle + 1 + ($random(seed) & 3));
      end
      // a beat not taken stays on the bus
      if (!(rsp.valid && !rsp_ready)) begin
        rsp = '0;
        if ((rsp_q.size() > 0) && (due_q[0] <= cycle)) begin
          rsp = rsp_q.pop_front();
          void'(due_q.pop_front());
        end
      end
      cmd_ready = (($random(seed) & 3) != 0);
    end
  end

endmodule

/* verif/tb_nice_core.sv */
// nice core testbench running custom3 instructions from a data file and checking the results
`timescale 1ns/1ns

module tb_nice_core;
  import nice_pkg::*;

  localparam int exp_base   = 'h20;
  localparam int erra_slot  = 'h28;
  localparam int count_slot = 'h30;
  localparam int list_base  = 'h40;
  localparam int row_words  = 6;

  logic     nice_clk;
  logic     nice_rst_n;
  logic     req_valid;
  xlen_t    req_inst;
  xlen_t    req_rs1;
  logic     req_ready;
  logic     rsp_valid;
  xlen_t    rsp_rdat;
  logic     rsp_err;
  logic     rsp_ready;
  icb_cmd_t icb_cmd;
  logic     icb_cmd_ready;
  icb_rsp_t icb_rsp;
  logic     icb_rsp_ready;
  logic     nice_active;
  logic     nice_mem_holdup;
  xlen_t    err_addr;

  xlen_t    vec [128];
  int       n_instr;
  int       value_errors;
  int       flow_errors;
  // expectations for the instruction in flight
  xlen_t    cur_rs1;
  logic     cur_read;
  int       cmd_count;
  int       rsp_count;

  nice_core_top u_nice_core_top (
    .nice_clk       (nice_clk),
    .nice_rst_n     (nice_rst_n),
    .req_valid      (req_valid),
    .req_inst       (req_inst),
    .req_rs1        (req_rs1),
    .req_ready      (req_ready),
    .rsp_valid      (rsp_valid),
    .rsp_rdat       (rsp_rdat),
    .rsp_err        (rsp_err),
    .rsp_ready      (rsp_ready),
    .icb_cmd        (icb_cmd),
    .icb_cmd_ready  (icb_cmd_ready),
    .icb_rsp        (icb_rsp),
    .icb_rsp_ready  (icb_rsp_ready),
    .nice_active    (nice_active),
    .nice_mem_holdup(nice_mem_holdup)
  );

  tb_icb_mem u_icb_mem (
    .nice_clk  (nice_clk),
    .nice_rst_n(nice_rst_n),
    .cmd       (icb_cmd),
    .cmd_ready (icb_cmd_ready),
    .rsp       (icb_rsp),
    .rsp_ready (icb_rsp_ready),
    .err_addr  (err_addr)
  );

  initial begin
    nice_clk = 1'b0;
    forever begin
      #5 nice_clk = ~nice_clk;
    end
  end

  task automatic note_mismatch(input string name, input xlen_t got, input xlen_t exp);
    value_errors++;
    $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
  endtask

  task automatic flag_failure(input string what);
    flow_errors++;
    $display("failure at %0t ns: %s", $time, what);
  endtask

  task automatic print_counts();
    $display("value errors: %0d, other failures: %0d", value_errors, flow_errors);
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // icb monitor, sampled at the falling edge
  //////////////////////////////////////////////////////////////////////////////
  always @(negedge nice_clk) begin
    if (nice_rst_n && icb_cmd.valid && icb_cmd_ready) begin
      if (icb_cmd.addr !== cur_rs1 + 32'(4 * cmd_count)) begin
        note_mismatch("icb_cmd.addr", icb_cmd.addr, cur_rs1 + 32'(4 * cmd_count));
      end
      if (icb_cmd.read !== cur_read) begin
        note_mismatch("icb_cmd.read", 32'(icb_cmd.read), 32'(cur_read));
      end
      if (icb_cmd.size !== 2'b10) begin
        note_mismatch("icb_cmd.size", 32'(icb_cmd.size), 32'd2);
      end
      // store data against the expected conv1 words
      if (!cur_read && (cmd_count < 8) && (icb_cmd.wdata !== vec[exp_base + cmd_count])) begin
        note_mismatch("icb_cmd.wdata", icb_cmd.wdata, vec[exp_base + cmd_count]);
      end
      cmd_count++;
    end
    // commands only come from the load and store states
    if (nice_rst_n && icb_cmd.valid &&
        ((nice_mem_holdup !== 1'b1) || (nice_active !== 1'b1))) begin
      flag_failure("nice_mem_holdup or nice_active low while a memory command was pending");
    end
    if (nice_rst_n && icb_rsp.valid && icb_rsp_ready) begin
      rsp_count++;
    end
    if (nice_rst_n && (icb_rsp_ready !== 1'b1)) begin
      flag_failure("icb_rsp_ready went low");
    end
  end

  task automatic run_instr(input int k);
    int   row;
    int   hold;
    logic err_first;
    row       = list_base + row_words * k;
    hold      = int'(vec[row+5]);
    cur_rs1   = vec[row+1];
    cur_read  = vec[row+3][0];
    cmd_count = 0;
    rsp_count = 0;
    @(posedge nice_clk);
    #1;
    req_valid = 1'b1;
    req_inst  = vec[row];
    req_rs1   = vec[row+1];
    rsp_ready = (hold == 0);
    @(negedge nice_clk);
    while (!req_ready) begin
      @(negedge nice_clk);
    end
    @(posedge nice_clk);
    #1;
    req_valid = 1'b0;
    req_inst  = '0;
    req_rs1   = '0;
    // the watchdog bounds this wait
    @(negedge nice_clk);
    while (!rsp_valid) begin
      @(negedge nice_clk);
    end
    err_first = rsp_err;
    if (rsp_err !== vec[row+4][0]) begin
      note_mismatch("rsp_err", 32'(rsp_err), 32'(vec[row+4][0]));
    end
    if (rsp_rdat !== '0) begin
      note_mismatch("rsp_rdat", rsp_rdat, '0);
    end
    if ((nice_active !== 1'b1) || (nice_mem_holdup !== 1'b0)) begin
      flag_failure("nice_active or nice_mem_holdup wrong while responding");
    end
    for (int i = 0; i < hold; i++) begin
      @(negedge nice_clk);
      if (rsp_valid !== 1'b1) begin
        flag_failure("rsp_valid dropped while rsp_ready was low");
      end
      if (rsp_err !== err_first) begin
        note_mismatch("rsp_err", 32'(rsp_err), 32'(err_first));
      end
      if (req_ready !== 1'b0) begin
        flag_failure("req_ready rose before the response transferred");
      end
    end
    if (hold > 0) begin
      @(posedge nice_clk);
      #1;
      rsp_ready = 1'b1;
      @(posedge nice_clk);
    end
    @(negedge nice_clk);
    if ((rsp_valid !== 1'b0) || (req_ready !== 1'b1) || (nice_active !== 1'b0)) begin
      flag_failure("controller did not return to idle after the response");
    end
    if (cmd_count !== int'(vec[row+2])) begin
      note_mismatch("icb command count", 32'(cmd_count), vec[row+2]);
    end
    if (rsp_count !== cmd_count) begin
      note_mismatch("icb response count", 32'(rsp_count), 32'(cmd_count));
    end
  endtask

  initial begin
    nice_rst_n   = 1'b0;
    req_valid    = 1'b0;
    req_inst     = '0;
    req_rs1      = '0;
    rsp_ready    = 1'b1;
    err_addr     = '0;
    cur_rs1      = '0;
    cur_read     = 1'b1;
    cmd_count    = 0;
    rsp_count    = 0;
    value_errors = 0;
    flow_errors  = 0;
    $readmemh("verif/nice_input.txt", vec);
    n_instr  = int'(vec[count_slot]);
    err_addr = vec[erra_slot];
    if (n_instr <= 0) begin
      flag_failure("data file holds no instructions");
    end
    repeat (5) @(posedge nice_clk);
    #1;
    nice_rst_n = 1'b1;
    @(negedge nice_clk);
    if ((req_ready !== 1'b1) || (rsp_valid !== 1'b0) || (icb_cmd.valid !== 1'b0)) begin
      flag_failure("handshake outputs wrong after reset");
    end
    if ((nice_active !== 1'b0) || (nice_mem_holdup !== 1'b0)) begin
      flag_failure("nice_active or nice_mem_holdup high after reset");
    end
    for (int k = 0; k < n_instr; k++) begin
      run_instr(k);
    end
    print_counts();
    if ((value_errors + flow_errors) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog sized from the instruction count
  initial begin
    @(posedge nice_rst_n);
    repeat (n_instr * 2000) @(posedge nice_clk);
    flag_failure("timeout, the DUT did not finish the instruction list");
    print_counts();
    $display("Finished with errors");
    $finish;
  end

endmodule

/* all.f */
hw/nice_pkg.sv
hw/nice_ctrl.sv
hw/nice_mem_agent.sv
hw/conv1_buffers.sv
hw/conv1_engine.sv
hw/nice_core_top.sv
verif/tb_icb_mem.sv
verif/tb_nice_core.sv

/* run.sh */
#!/usr/bin/env bash
# compile the nice core testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_nice_core -f all.f > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status, see $build_log"
  exit 1
fi

./obj_dir/Vtb_nice_core > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$sim_log"; then
  exit 1
fi
exit 0

/* verif/nice_input.txt */
// 32-bit hex words by address: kernels @000, image @010, results @020, error addr @028
// rows @040: inst, rs1 base, commands, read 1 or write 0, rsp err, rsp_ready hold cycles
@000
0c0c0c0c 0c0c0c0c 6666660c 66666666
eeee6666 020202ee f87a7a7a f8f8f8f8
f8f8f8f8 7f7f7f7f 7f7f7f7f 0000007f
// image rows of 8 pixels, two words per row
@010
8910107f 10101010
10101010 9d101093
10108910 10a71010
10931010 10109d10
10101010 b11010a7
9d101093 10101010
10a71010 1010b110
10109d10 10bb1010
// conv1 results, four bytes per word in kernel, row, column order
@020
a7a6a6a4 c5b3b3a2 aba6a6a0 9f9f9f9f e8d2d2bc
@028
00000300
// number of instruction rows
@030
00000006
@040
1605207b 000002f0 0000000c 00000001 00000001 00000000
1605207b 00000000 0000000c 00000001 00000000 00000003
2205207b 00000000 00000000 00000001 00000001 00000004
1605202b 00000000 00000000 00000001 00000001 00000000
1e05207b 00000040 00000010 00000001 00000000 00000002
2005207b 00000200 00000005 00000000 00000000 00000000
